/* source/tok_consts.svh */
`ifndef TOK_CONSTS_SVH
`define TOK_CONSTS_SVH

// character and code widths.
`define TOK_BYTE_W 8
`define TOK_CODE_W 8

// text buffer holds the terminator too.
`define TOK_TEXT_DEPTH 32
`define TOK_TEXT_AW 5

`define TOK_VOCAB_DEPTH 64
`define TOK_VOCAB_AW 6

`define TOK_OUT_DEPTH 4

`define TOK_UNK_CODE 254
`define TOK_END_CODE 255

`endif

/* source/tok_pkg.sv */
`default_nettype none

`include "tok_consts.svh"

package tok_pkg;

    typedef logic [`TOK_BYTE_W-1:0] byte_t;
    typedef logic [`TOK_CODE_W-1:0] code_t;
    typedef logic [`TOK_TEXT_AW-1:0] text_addr_t;
    typedef logic [`TOK_VOCAB_AW-1:0] vocab_addr_t;

    typedef enum logic [2:0] {
        IDLE,
        POS_START,
        FETCH,
        COMPARE,
        SKIP_FETCH,
        SKIP_CHECK,
        EMIT,
        FINISH
    } ctrl_state_t;

endpackage

`default_nettype wire

/* source/tok_text_buffer.sv */
`default_nettype none

`include "tok_consts.svh"

module tok_text_buffer (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                text_valid,
    output logic                text_ready,
    input  tok_pkg::byte_t      text_data,
    input  tok_pkg::text_addr_t text_raddr,
    output tok_pkg::byte_t      text_rdata,
    output logic                text_loaded,
    input  logic                text_release
);
    localparam tok_pkg::text_addr_t LAST_SLOT = tok_pkg::text_addr_t'(`TOK_TEXT_DEPTH - 1);

    tok_pkg::byte_t      mem [`TOK_TEXT_DEPTH];
    tok_pkg::text_addr_t wr_ptr;
    logic                accept;

    // input closes once the terminator is stored.
    assign text_ready = !text_loaded;
    assign accept = text_valid && text_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            text_loaded <= 1'b0;
        end else if (text_release) begin
            wr_ptr <= '0;
            text_loaded <= 1'b0;
        end else if (accept) begin
            wr_ptr <= wr_ptr + tok_pkg::text_addr_t'(1);
            if (text_data == '0) begin
                text_loaded <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            mem[wr_ptr] <= text_data;
        end
    end

    always_ff @(posedge clk) begin
        text_rdata <= mem[text_raddr];
    end

    // the last slot is reserved for the terminator.
    a_no_overflow: assert property (
        @(posedge clk) disable iff (!rst_n)
        (accept && wr_ptr == LAST_SLOT) |-> (text_data == '0)
    );

endmodule

`default_nettype wire

/* source/tok_vocab_store.sv */
`default_nettype none

`include "tok_consts.svh"

module tok_vocab_store (
    input  logic                 clk,
    input  logic                 vocab_we,
    input  tok_pkg::vocab_addr_t vocab_addr,
    input  tok_pkg::byte_t       vocab_data,
    input  tok_pkg::vocab_addr_t vocab_raddr,
    output tok_pkg::byte_t       vocab_rdata
);
    // entries are zero-terminated strings, an empty entry ends the list.
    tok_pkg::byte_t mem [`TOK_VOCAB_DEPTH];

    always_ff @(posedge clk) begin
        if (vocab_we) begin
            mem[vocab_addr] <= vocab_data;
        end
    end

    // read data lands one cycle after the address.
    always_ff @(posedge clk) begin
        vocab_rdata <= mem[vocab_raddr];
    end

endmodule

`default_nettype wire

/* source/tok_match_ctrl.sv */
`default_nettype none

`include "tok_consts.svh"

module tok_match_ctrl (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 text_loaded,
    output logic                 text_release,
    output tok_pkg::text_addr_t  text_raddr,
    input  tok_pkg::byte_t       text_rdata,
    output tok_pkg::vocab_addr_t vocab_raddr,
    input  tok_pkg::byte_t       vocab_rdata,
    output logic                 push_valid,
    output tok_pkg::code_t       push_code,
    output logic                 push_last,
    input  logic                 push_ready
);
    tok_pkg::ctrl_state_t state;
    tok_pkg::text_addr_t  pos;
    tok_pkg::text_addr_t  offset;
    tok_pkg::vocab_addr_t vaddr;
    tok_pkg::code_t       index;
    logic                 vocab_end;
    logic                 text_end;
    logic                 chars_equal;

    assign vocab_end = (vocab_rdata == '0);
    assign text_end = (text_rdata == '0);
    assign chars_equal = (vocab_rdata == text_rdata);

    assign text_raddr = pos + offset;
    assign vocab_raddr = vaddr;
    assign push_valid = (state == tok_pkg::EMIT);
    assign text_release = (state == tok_pkg::FINISH);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= tok_pkg::IDLE;
            pos <= '0;
            offset <= '0;
            vaddr <= '0;
            index <= '0;
        end else begin
            case (state)
                tok_pkg::IDLE: begin
                    if (text_loaded) begin
                        state <= tok_pkg::POS_START;
                    end
                end
                tok_pkg::POS_START: begin
                    offset <= '0;
                    vaddr <= '0;
                    index <= '0;
                    state <= tok_pkg::FETCH;
                end
                tok_pkg::FETCH: begin
                    state <= tok_pkg::COMPARE;
                end
                tok_pkg::COMPARE: begin
                    if (vocab_end) begin
                        // end of list or end of a matched entry.
                        if (offset == '0) begin
                            if (!text_end) begin
                                pos <= pos + tok_pkg::text_addr_t'(1);
                            end
                        end else begin
                            pos <= pos + offset;
                        end
                        state <= tok_pkg::EMIT;
                    end else if (chars_equal) begin
                        offset <= offset + tok_pkg::text_addr_t'(1);
                        vaddr <= vaddr + tok_pkg::vocab_addr_t'(1);
                        state <= tok_pkg::FETCH;
                    end else begin
                        vaddr <= vaddr + tok_pkg::vocab_addr_t'(1);
                        state <= tok_pkg::SKIP_FETCH;
                    end
                end
                tok_pkg::SKIP_FETCH: begin
                    state <= tok_pkg::SKIP_CHECK;
                end
                tok_pkg::SKIP_CHECK: begin
                    // step past the terminator into the next entry.
                    vaddr <= vaddr + tok_pkg::vocab_addr_t'(1);
                    if (vocab_end) begin
                        index <= index + tok_pkg::code_t'(1);
                        offset <= '0;
                        state <= tok_pkg::FETCH;
                    end else begin
                        state <= tok_pkg::SKIP_FETCH;
                    end
                end
                tok_pkg::EMIT: begin
                    if (push_ready) begin
                        state <= push_last ? tok_pkg::FINISH : tok_pkg::POS_START;
                    end
                end
                tok_pkg::FINISH: begin
                    pos <= '0;
                    state <= tok_pkg::IDLE;
                end
                default: begin
                    state <= tok_pkg::IDLE;
                end
            endcase
        end
    end

    // code is chosen in the same cycle the FSM heads for EMIT.
    always_ff @(posedge clk) begin
        if (state == tok_pkg::COMPARE && vocab_end) begin
            if (offset != '0) begin
                push_code <= index;
                push_last <= 1'b0;
            end else if (text_end) begin
                push_code <= tok_pkg::code_t'(`TOK_END_CODE);
                push_last <= 1'b1;
            end else begin
                push_code <= tok_pkg::code_t'(`TOK_UNK_CODE);
                push_last <= 1'b0;
            end
        end
    end

    a_legal_state: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(state) && (state inside {tok_pkg::IDLE, tok_pkg::POS_START,
            tok_pkg::FETCH, tok_pkg::COMPARE, tok_pkg::SKIP_FETCH,
            tok_pkg::SKIP_CHECK, tok_pkg::EMIT, tok_pkg::FINISH})
    );

endmodule

`default_nettype wire

/* source/tok_code_queue.sv */
`default_nettype none

`include "tok_consts.svh"

module tok_code_queue (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           push_valid,
    output logic           push_ready,
    input  tok_pkg::code_t push_code,
    input  logic           push_last,
    output logic           code_valid,
    input  logic           code_ready,
    output tok_pkg::code_t code_data,
    output logic           code_last
);
    localparam int PTR_W = $clog2(`TOK_OUT_DEPTH);
    localparam logic [PTR_W:0] FULL_COUNT = (PTR_W + 1)'(`TOK_OUT_DEPTH);

    tok_pkg::code_t   code_mem [`TOK_OUT_DEPTH];
    logic             last_mem [`TOK_OUT_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             push;
    logic             pop;

    assign push_ready = (count != FULL_COUNT);
    assign code_valid = (count != '0);
    assign push = push_valid && push_ready;
    assign pop = code_valid && code_ready;

    // head entry drives the output directly, so it holds until popped.
    assign code_data = code_mem[rd_ptr];
    assign code_last = last_mem[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            code_mem[wr_ptr] <= push_code;
            last_mem[wr_ptr] <= push_last;
        end
    end

    // a push into a full queue or a pop from an empty one breaks these.
    a_count_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        count <= FULL_COUNT
    );

    a_ptr_match: assert property (
        @(posedge clk) disable iff (!rst_n)
        (wr_ptr - rd_ptr) == count[PTR_W-1:0]
    );

endmodule

`default_nettype wire

/* source/tok_encoder_top.sv */
`default_nettype none

module tok_encoder_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 text_valid,
    output logic                 text_ready,
    input  tok_pkg::byte_t       text_data,
    output logic                 code_valid,
    input  logic                 code_ready,
    output tok_pkg::code_t       code_data,
    output logic                 code_last,
    input  logic                 vocab_we,
    input  tok_pkg::vocab_addr_t vocab_addr,
    input  tok_pkg::byte_t       vocab_data
);
    logic                 text_loaded;
    logic                 text_release;
    tok_pkg::text_addr_t  text_raddr;
    tok_pkg::byte_t       text_rdata;
    tok_pkg::vocab_addr_t vocab_raddr;
    tok_pkg::byte_t       vocab_rdata;
    logic                 push_valid;
    logic                 push_ready;
    tok_pkg::code_t       push_code;
    logic                 push_last;

    tok_text_buffer text_buf0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .text_valid   (text_valid),
        .text_ready   (text_ready),
        .text_data    (text_data),
        .text_raddr   (text_raddr),
        .text_rdata   (text_rdata),
        .text_loaded  (text_loaded),
        .text_release (text_release)
    );

    tok_vocab_store vocab0 (
        .clk         (clk),
        .vocab_we    (vocab_we),
        .vocab_addr  (vocab_addr),
        .vocab_data  (vocab_data),
        .vocab_raddr (vocab_raddr),
        .vocab_rdata (vocab_rdata)
    );

    tok_match_ctrl ctrl0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .text_loaded  (text_loaded),
        .text_release (text_release),
        .text_raddr   (text_raddr),
        .text_rdata   (text_rdata),
        .vocab_raddr  (vocab_raddr),
        .vocab_rdata  (vocab_rdata),
        .push_valid   (push_valid),
        .push_code    (push_code),
        .push_last    (push_last),
        .push_ready   (push_ready)
    );

    tok_code_queue queue0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .push_valid (push_valid),
        .push_ready (push_ready),
        .push_code  (push_code),
        .push_last  (push_last),
        .code_valid (code_valid),
        .code_ready (code_ready),
        .code_data  (code_data),
        .code_last  (code_last)
    );

endmodule

`default_nettype wire

/* verif/tok_encoder_tb.sv */
`default_nettype none

`include "tok_consts.svh"

module tok_encoder_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam string STIM_FILE = "verif/tok_stimulus.txt";
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic                 text_valid;
    logic                 text_ready;
    tok_pkg::byte_t       text_data;
    logic                 code_valid;
    logic                 code_ready = 1'b0;
    tok_pkg::code_t       code_data;
    logic                 code_last;
    logic                 vocab_we;
    tok_pkg::vocab_addr_t vocab_addr;
    tok_pkg::byte_t       vocab_data;

    logic [31:0]          lfsr_state = 32'd67158;
    logic                 gap_next = 1'b0;
    logic                 hold_ready = 1'b0;
    tok_pkg::byte_t       vocab_bytes[$];
    tok_pkg::byte_t       text_bytes[$];
    tok_pkg::code_t       exp_codes[$];

    tok_encoder_top dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .text_valid (text_valid),
        .text_ready (text_ready),
        .text_data  (text_data),
        .code_valid (code_valid),
        .code_ready (code_ready),
        .code_data  (code_data),
        .code_last  (code_last),
        .vocab_we   (vocab_we),
        .vocab_addr (vocab_addr),
        .vocab_data (vocab_data)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ LFSR_TAPS;
        end
        return state >> 1;
    endfunction

    task automatic take_bit(output logic bit_out);
        bit_out = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
    endtask

    // bits are drawn at the falling edge, so the driver reads a settled gap flag.
    always begin
        logic ready_a;
        logic ready_b;
        logic gap_a;
        logic gap_b;
        @(negedge clk);
        take_bit(ready_a);
        take_bit(ready_b);
        take_bit(gap_a);
        take_bit(gap_b);
        gap_next = gap_a & gap_b;
        @(posedge clk);
        #2;
        code_ready = !hold_ready && (ready_a | ready_b);
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_code(input string name, input tok_pkg::code_t expected,
                              input tok_pkg::code_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("[ERROR] %s: expected code %0d, actual %0d",
                                name, expected, actual));
        end
    endtask

    task automatic check_last(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            abort_run($sformatf("[ERROR] %s: expected last %0b, actual %0b",
                                name, expected, actual));
        end
    endtask

    function automatic bit is_blank(input logic [7:0] c);
        return c == 8'h20 || c == 8'h09 || c == 8'h0a || c == 8'h0d;
    endfunction

    task automatic store_value(input logic [7:0] kind, input int value);
        case (kind)
            "V": vocab_bytes.push_back(tok_pkg::byte_t'(value));
            "T": text_bytes.push_back(tok_pkg::byte_t'(value));
            "C": exp_codes.push_back(tok_pkg::code_t'(value));
            default: abort_run($sformatf("unknown record kind %c in the stimulus file", kind));
        endcase
    endtask

    task automatic read_stimulus();
        int          fd;
        int          pos;
        string       line;
        string       field;
        logic [7:0]  kind;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            abort_run({"cannot open ", STIM_FILE});
        end
        while ($fgets(line, fd) != 0) begin
            kind = line.getc(0);
            if (line.len() < 2 || kind == "#") begin
                continue;
            end
            field = "";
            for (pos = 1; pos < line.len(); pos++) begin
                if (!is_blank(line.getc(pos))) begin
                    field = {field, line.substr(pos, pos)};
                end else if (field.len() > 0) begin
                    store_value(kind, field.atohex());
                    field = "";
                end
            end
            if (field.len() > 0) begin
                store_value(kind, field.atohex());
            end
        end
        $fclose(fd);
    endtask

    task automatic load_vocab();
        foreach (vocab_bytes[i]) begin
            @(posedge clk);
            #2;
            vocab_we = 1'b1;
            vocab_addr = tok_pkg::vocab_addr_t'(i);
            vocab_data = vocab_bytes[i];
        end
        @(posedge clk);
        #2;
        vocab_we = 1'b0;
    endtask

    task automatic send_text(input int start, input int count);
        bit accepted;
        for (int i = start; i < start + count; i++) begin
            accepted = 1'b0;
            while (!accepted) begin
                @(posedge clk);
                #2;
                text_valid = !gap_next;
                text_data = text_bytes[i];
                @(negedge clk);
                accepted = text_valid && text_ready;
            end
        end
        @(posedge clk);
        #2;
        text_valid = 1'b0;
    endtask

    // term_age counts falling edges since the terminator handshake.
    task automatic collect_codes(input int text_id, input int start, input int count);
        int    got;
        int    term_age;
        int    hold_left;
        bit    finished;
        logic  exp_last;
        string name;
        got = 0;
        term_age = -1;
        finished = 1'b0;
        hold_left = 0;
        // with more codes than queue slots, code_ready stays low until the FSM waits in EMIT.
        if (count > `TOK_OUT_DEPTH) begin
            hold_left = (`TOK_OUT_DEPTH + 1) * (2 * vocab_bytes.size() + 4);
            hold_ready = 1'b1;
        end
        while (!finished) begin
            @(negedge clk);
            if (term_age >= 0) begin
                term_age++;
            end
            if (term_age == 1 && text_ready) begin
                abort_run($sformatf("text %0d: text_ready still high after the terminator",
                                    text_id));
            end
            if (term_age >= 1 && text_ready && count - got > `TOK_OUT_DEPTH) begin
                abort_run($sformatf("text %0d: text_ready rose before all codes were queued",
                                    text_id));
            end
            if (term_age < 0 && text_valid && text_ready && text_data == '0) begin
                term_age = 0;
            end
            if (term_age >= 0 && hold_left > 0) begin
                hold_left--;
                if (hold_left == 0) begin
                    if (!code_valid) begin
                        abort_run($sformatf("text %0d: no code queued during the stall",
                                            text_id));
                    end
                    hold_ready = 1'b0;
                end
            end
            if (code_valid && code_ready) begin
                name = $sformatf("text %0d code %0d", text_id, got);
                exp_last = (exp_codes[start + got] == tok_pkg::code_t'(`TOK_END_CODE));
                check_code(name, exp_codes[start + got], code_data);
                check_last(name, exp_last, code_last);
                got++;
                finished = code_last;
            end
        end
        @(negedge clk);
        if (!text_ready) begin
            abort_run($sformatf("text %0d: text_ready still low after the last code", text_id));
        end
    endtask

    task automatic run_watchdog(input int cycles);
        repeat (cycles) @(posedge clk);
        abort_run($sformatf("watchdog expired after %0d cycles without finishing", cycles));
    endtask

    initial begin
        int text_count;
        int end_count;
        int budget;
        int text_len;
        int code_len;
        int text_start;
        int code_start;
        rst_n = 1'b0;
        text_valid = 1'b0;
        text_data = '0;
        vocab_we = 1'b0;
        vocab_addr = '0;
        vocab_data = '0;
        read_stimulus();
        if (vocab_bytes.size() > `TOK_VOCAB_DEPTH) begin
            abort_run("vocabulary in the stimulus file does not fit the vocabulary memory");
        end

        // cycle budget scales with text length times vocabulary size.
        text_count = 0;
        text_len = 0;
        budget = 5 + vocab_bytes.size() + 20;
        foreach (text_bytes[i]) begin
            text_len++;
            if (text_bytes[i] == '0) begin
                text_count++;
                budget += text_len * vocab_bytes.size() * 4 + 200;
                text_len = 0;
            end
        end
        end_count = 0;
        code_len = 0;
        foreach (exp_codes[i]) begin
            code_len++;
            if (exp_codes[i] == tok_pkg::code_t'(`TOK_END_CODE)) begin
                end_count++;
                code_len = 0;
            end
        end
        if (text_count == 0 || text_count != end_count || text_len != 0 || code_len != 0) begin
            abort_run("stimulus file texts and expected code lists do not pair up");
        end
        fork
            run_watchdog(budget);
        join_none

        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        if (text_ready !== 1'b1 || code_valid !== 1'b0) begin
            abort_run("text_ready or code_valid at a wrong level after reset");
        end
        load_vocab();

        text_start = 0;
        code_start = 0;
        for (int t = 0; t < text_count; t++) begin
            text_len = 1;
            while (text_bytes[text_start + text_len - 1] != '0) begin
                text_len++;
            end
            code_len = 1;
            while (exp_codes[code_start + code_len - 1] != tok_pkg::code_t'(`TOK_END_CODE)) begin
                code_len++;
            end
            fork
                send_text(text_start, text_len);
                collect_codes(t, code_start, code_len);
            join
            text_start += text_len;
            code_start += code_len;
        end
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+source
source/tok_pkg.sv
source/tok_text_buffer.sv
source/tok_vocab_store.sv
source/tok_match_ctrl.sv
source/tok_code_queue.sv
source/tok_encoder_top.sv
verif/tok_encoder_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tok_encoder_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Simulation PASSED
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || { echo "pass message not found in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verif/tok_stimulus.txt */
# each line is a record kind followed by hex bytes.
# V vocabulary bytes from address 0, T text bytes ending in 00, C expected codes ending in ff.
# entries: 0 a, 1 b, 2 abc, 3 the, 4 th, 5 t, 6 e, 7 xyz, 8 x, 9 space.
V 61 00 62 00 61 62 63 00
V 74 68 65 00 74 68 00 74 00 65 00
V 78 79 7a 00 78 00 20 00 00
# "ab" maps one entry per character.
T 61 62 00
C 00 01 ff
# "abc" takes the earlier a over the later abc, c has no entry.
T 61 62 63 00
C 00 01 fe ff
# "the th" takes the before th, the trailing th fails the on the terminator.
T 74 68 65 20 74 68 00
C 03 09 04 ff
# "xyq" fails xyz at q and falls back to x.
T 78 79 71 00
C 08 fe fe ff
# empty text.
T 00
C ff
# "the cat te" mixes partial matches and unknown characters.
T 74 68 65 20 63 61 74 20 74 65 00
C 03 09 fe 00 05 09 05 06 ff
# "xyz abcab" is long enough to fill the output queue.
T 78 79 7a 20 61 62 63 61 62 00
C 07 09 00 01 fe 00 01 ff
